//--- verilog/rv_isa_pkg.sv
package rv_isa_pkg;

    // raw instruction word as fetched from memory
    typedef logic [31:0] instr_t;

    // major opcode, bits [6:0]
    typedef logic [6:0] opcode_t;

    // funct7 field, bits [31:25]
    typedef logic [6:0] funct7_t;

    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_REG    = 7'b0110011;  // R-type alu, also mul/div

    // M extension marker on R-type ops
    localparam funct7_t FUNCT7_MULDIV = 7'b0000001;

endpackage

//--- verilog/fetch_pkg.sv
package fetch_pkg;

    // byte address on the fetch bus
    typedef logic [31:0] addr_t;

    // what follows an issued instruction
    typedef enum logic [1:0] {
        NK_SEQ      = 2'd0,
        NK_JUMP     = 2'd1,
        NK_REDIRECT = 2'd2,   // jalr / branch, target from execute
        NK_MULDIV   = 2'd3
    } next_kind_e;

    typedef enum logic [2:0] {
        SQ_IDLE     = 3'd0,
        SQ_FETCH    = 3'd1,
        SQ_ISSUE    = 3'd2,
        SQ_REDIRECT = 3'd3,
        SQ_MULDIV   = 3'd4
    } seq_state_e;

    typedef enum logic {
        WB_IDLE = 1'b0,
        WB_BUS  = 1'b1
    } wb_state_e;

    localparam addr_t PC_STEP = 32'd4;

endpackage

//--- verilog/fetch_ifs.sv
`timescale 1ns/100ps

// one outstanding fetch between sequencer and bus master
interface fetch_req_if;
    logic                req;        // single-cycle pulse
    fetch_pkg::addr_t    pc;
    logic                rsp_valid;  // single-cycle pulse
    rv_isa_pkg::instr_t  rsp_word;

    modport seq (
        output req,
        output pc,
        input  rsp_valid,
        input  rsp_word
    );

    modport bus (
        input  req,
        input  pc,
        output rsp_valid,
        output rsp_word
    );
endinterface

// handoff of a fetched word to issue, and its next-pc report back
interface pc_update_if;
    logic                   load;
    fetch_pkg::addr_t       load_pc;
    rv_isa_pkg::instr_t     load_word;
    logic                   taken;
    fetch_pkg::next_kind_e  kind;
    fetch_pkg::addr_t       jump_target;  // only meaningful for NK_JUMP

    modport issue (
        input  load,
        input  load_pc,
        input  load_word,
        output taken,
        output kind,
        output jump_target
    );

    modport seq (
        output load,
        output load_pc,
        output load_word,
        input  taken,
        input  kind,
        input  jump_target
    );
endinterface

//--- verilog/wb_fetch_master.sv
`timescale 1ns/100ps

module wb_fetch_master (
    input  logic               clk,
    input  logic               rst_n,
    fetch_req_if.bus           fetch,
    output logic               wb_cyc,
    output logic               wb_stb,
    output fetch_pkg::addr_t   wb_adr,
    input  rv_isa_pkg::instr_t wb_dat_i,
    input  logic               wb_ack
);

    fetch_pkg::wb_state_e state;
    fetch_pkg::addr_t     adr_q;
    rv_isa_pkg::instr_t   word_q;
    logic                 rsp_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= fetch_pkg::WB_IDLE;
            rsp_q <= 1'b0;
        end else begin
            rsp_q <= 1'b0;
            case (state)
                fetch_pkg::WB_IDLE: begin
                    if (fetch.req) begin
                        state <= fetch_pkg::WB_BUS;
                    end
                end
                fetch_pkg::WB_BUS: begin
                    if (wb_ack) begin
                        state <= fetch_pkg::WB_IDLE;
                        rsp_q <= 1'b1;
                    end
                end
                default: state <= fetch_pkg::WB_IDLE;
            endcase
        end
    end

    // address and data path
    always_ff @(posedge clk) begin
        if (state == fetch_pkg::WB_IDLE && fetch.req) begin
            adr_q <= fetch.pc;
        end
        if (state == fetch_pkg::WB_BUS && wb_ack) begin
            word_q <= wb_dat_i;   // sampled on the ack cycle
        end
    end

    // classic cycle, cyc and stb move together
    assign wb_cyc = (state == fetch_pkg::WB_BUS);
    assign wb_stb = (state == fetch_pkg::WB_BUS);
    assign wb_adr = adr_q;

    assign fetch.rsp_valid = rsp_q;
    assign fetch.rsp_word  = word_q;

    // slave may stall, master must hold the request
    stb_held_until_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr))
    ) else $error("wb_stb or wb_adr changed before wb_ack");

endmodule

//--- verilog/pc_sequencer.sv
`timescale 1ns/100ps

module pc_sequencer #(
    parameter fetch_pkg::addr_t RESET_VECTOR = 32'h8000_0000
) (
    input  logic             clk,
    input  logic             rst_n,
    fetch_req_if.seq         fetch,
    pc_update_if.seq         upd,
    input  logic             redirect_valid,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             md_done
);

    fetch_pkg::seq_state_e state;
    fetch_pkg::seq_state_e state_nxt;
    fetch_pkg::addr_t      pc;
    fetch_pkg::addr_t      pc_nxt;
    logic                  go;       // start a fetch on the next cycle
    logic                  req_q;
    logic                  pending;  // fetch issued, word not back yet

    always_comb begin
        state_nxt = state;
        pc_nxt    = pc;
        go        = 1'b0;
        case (state)
            fetch_pkg::SQ_IDLE: begin
                state_nxt = fetch_pkg::SQ_FETCH;
                go        = 1'b1;
            end
            fetch_pkg::SQ_FETCH: begin
                if (fetch.rsp_valid) begin
                    state_nxt = fetch_pkg::SQ_ISSUE;
                end
            end
            fetch_pkg::SQ_ISSUE: begin
                // hold here while downstream stalls
                if (upd.taken) begin
                    case (upd.kind)
                        fetch_pkg::NK_SEQ: begin
                            pc_nxt    = pc + fetch_pkg::PC_STEP;
                            state_nxt = fetch_pkg::SQ_FETCH;
                            go        = 1'b1;
                        end
                        fetch_pkg::NK_JUMP: begin
                            pc_nxt    = upd.jump_target;
                            state_nxt = fetch_pkg::SQ_FETCH;
                            go        = 1'b1;
                        end
                        fetch_pkg::NK_REDIRECT: state_nxt = fetch_pkg::SQ_REDIRECT;
                        fetch_pkg::NK_MULDIV:   state_nxt = fetch_pkg::SQ_MULDIV;
                    endcase
                end
            end
            fetch_pkg::SQ_REDIRECT: begin
                if (redirect_valid) begin
                    pc_nxt    = redirect_pc;
                    state_nxt = fetch_pkg::SQ_FETCH;
                    go        = 1'b1;
                end
            end
            fetch_pkg::SQ_MULDIV: begin
                if (md_done) begin
                    pc_nxt    = pc + fetch_pkg::PC_STEP;  // pc held until unit finishes
                    state_nxt = fetch_pkg::SQ_FETCH;
                    go        = 1'b1;
                end
            end
            default: state_nxt = fetch_pkg::SQ_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= fetch_pkg::SQ_IDLE;
            pc      <= RESET_VECTOR;
            req_q   <= 1'b0;
            pending <= 1'b0;
        end else begin
            state <= state_nxt;
            pc    <= pc_nxt;
            req_q <= go;
            if (req_q) begin
                pending <= 1'b1;
            end else if (fetch.rsp_valid) begin
                pending <= 1'b0;
            end
        end
    end

    assign fetch.req = req_q;
    assign fetch.pc  = pc;

    // word goes straight to issue with the pc it came from
    assign upd.load      = fetch.rsp_valid;
    assign upd.load_pc   = pc;
    assign upd.load_word = fetch.rsp_word;

    redirect_in_wait: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect_valid |-> (state == fetch_pkg::SQ_REDIRECT)
    ) else $error("redirect_valid outside SQ_REDIRECT");

    md_done_in_wait: assert property (
        @(posedge clk) disable iff (!rst_n)
        md_done |-> (state == fetch_pkg::SQ_MULDIV)
    ) else $error("md_done outside SQ_MULDIV");

    single_outstanding: assert property (
        @(posedge clk) disable iff (!rst_n)
        fetch.req |-> !pending
    ) else $error("fetch request while a response is pending");

endmodule

//--- verilog/instr_issue.sv
`timescale 1ns/100ps

module instr_issue (
    input  logic               clk,
    input  logic               rst_n,
    pc_update_if.issue         upd,
    output logic               inst_valid,
    input  logic               inst_ready,
    output fetch_pkg::addr_t   inst_pc,
    output rv_isa_pkg::instr_t inst_word
);

    rv_isa_pkg::instr_t  word_q;
    fetch_pkg::addr_t    pc_q;
    logic                valid_q;
    logic                taken_q;
    rv_isa_pkg::opcode_t opcode;
    rv_isa_pkg::funct7_t funct7;
    fetch_pkg::addr_t    j_imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            taken_q <= 1'b0;
        end else begin
            taken_q <= valid_q && inst_ready;  // one cycle after transfer
            if (upd.load) begin
                valid_q <= 1'b1;
            end else if (valid_q && inst_ready) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (upd.load) begin
            word_q <= upd.load_word;
            pc_q   <= upd.load_pc;
        end
    end

    // predecode, word_q still holds on the taken cycle
    assign opcode = word_q[6:0];
    assign funct7 = word_q[31:25];
    assign j_imm  = {{12{word_q[31]}}, word_q[19:12], word_q[20], word_q[30:21], 1'b0};

    always_comb begin
        case (opcode)
            rv_isa_pkg::OP_JAL:    upd.kind = fetch_pkg::NK_JUMP;
            rv_isa_pkg::OP_JALR,
            rv_isa_pkg::OP_BRANCH: upd.kind = fetch_pkg::NK_REDIRECT;
            rv_isa_pkg::OP_REG: begin
                if (funct7 == rv_isa_pkg::FUNCT7_MULDIV) begin
                    upd.kind = fetch_pkg::NK_MULDIV;
                end else begin
                    upd.kind = fetch_pkg::NK_SEQ;
                end
            end
            default: upd.kind = fetch_pkg::NK_SEQ;
        endcase
    end

    assign upd.jump_target = pc_q + j_imm;
    assign upd.taken       = taken_q;

    assign inst_valid = valid_q;
    assign inst_pc    = pc_q;
    assign inst_word  = word_q;

    // stalled instruction must not move under the consumer
    hold_while_stalled: assert property (
        @(posedge clk) disable iff (!rst_n)
        (inst_valid && !inst_ready) |=>
            (inst_valid && $stable(inst_word) && $stable(inst_pc))
    ) else $error("instruction changed while inst_ready low");

endmodule

//--- verilog/fetch_top.sv
`timescale 1ns/100ps

module fetch_top #(
    parameter fetch_pkg::addr_t RESET_VECTOR = 32'h8000_0000
) (
    input  logic               clk,
    input  logic               rst_n,
    // wishbone fetch port, read only
    output logic               wb_cyc,
    output logic               wb_stb,
    output fetch_pkg::addr_t   wb_adr,
    input  rv_isa_pkg::instr_t wb_dat_i,
    input  logic               wb_ack,
    // downstream stage
    output logic               inst_valid,
    input  logic               inst_ready,
    output fetch_pkg::addr_t   inst_pc,
    output rv_isa_pkg::instr_t inst_word,
    // from execute
    input  logic               redirect_valid,
    input  fetch_pkg::addr_t   redirect_pc,
    input  logic               md_done
);

    fetch_req_if fetch_bus ();
    pc_update_if pc_upd ();

    wb_fetch_master u_wb_master (
        .clk      (clk),
        .rst_n    (rst_n),
        .fetch    (fetch_bus.bus),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack)
    );

    pc_sequencer #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_pc_seq (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch          (fetch_bus.seq),
        .upd            (pc_upd.seq),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .md_done        (md_done)
    );

    instr_issue u_issue (
        .clk        (clk),
        .rst_n      (rst_n),
        .upd        (pc_upd.issue),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst_pc    (inst_pc),
        .inst_word  (inst_word)
    );

endmodule

//--- sim/fetch_checker.sv
`timescale 1ns/100ps

module fetch_checker #(
    parameter logic [31:0] RESET_VECTOR = 32'h8000_0000
) (
    input logic        clk,
    input logic        rst_n,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic [31:0] wb_adr,
    input logic [31:0] wb_dat_i,
    input logic        wb_ack,
    input logic        inst_valid,
    input logic        inst_ready,
    input logic [31:0] inst_pc,
    input logic [31:0] inst_word,
    input logic        redirect_valid,
    input logic [31:0] redirect_pc,
    input logic        md_done
);

    int          transfers = 0;
    int          value_errors = 0;
    int          protocol_errors = 0;

    logic        have_prev = 1'b0;
    logic [31:0] prev_pc;
    logic [31:0] prev_word;
    logic [31:0] last_redirect = '0;
    logic [31:0] exp_pc = RESET_VECTOR;
    logic [31:0] fetch_adr;
    logic [31:0] fetch_word;
    logic        prev_cyc = 1'b0;
    logic        prev_valid = 1'b0;
    logic        stalled = 1'b0;
    logic [31:0] stall_pc;
    logic [31:0] stall_word;
    logic        wait_redirect = 1'b0;
    logic        wait_md = 1'b0;

    // next pc from the isa rules
    function automatic logic [31:0] ref_next_pc(input logic [31:0] pc, input logic [31:0] w,
                                                input logic [31:0] redir);
        logic [31:0] imm;
        imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        case (w[6:0])
            7'b1101111:             return pc + imm;
            7'b1100111, 7'b1100011: return redir;
            default:                return pc + 32'd4;
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] expv, input logic [31:0] act);
        if (expv !== act) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, expv, act);
            value_errors++;
        end
    endtask

    task automatic protocol_error(input string msg);
        $display("%0t protocol error: %s", $time, msg);
        protocol_errors++;
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            if (wb_cyc || inst_valid) begin
                protocol_error("wb_cyc or inst_valid high during reset");
            end
        end else begin
            if (wb_stb !== wb_cyc) begin
                protocol_error("wb_stb and wb_cyc not asserted together");
            end
            if (redirect_valid) begin
                last_redirect = redirect_pc;
                wait_redirect = 1'b0;
            end
            if (md_done) begin
                wait_md = 1'b0;
            end
            if (wb_cyc && !prev_cyc) begin  // fetch starts
                if (wait_redirect) begin
                    protocol_error("fetch started before redirect_valid");
                end
                if (wait_md) begin
                    protocol_error("fetch started before md_done");
                end
                exp_pc = have_prev ? ref_next_pc(prev_pc, prev_word, last_redirect)
                                   : RESET_VECTOR;
                compare("wb_adr", exp_pc, wb_adr);
            end
            if (wb_cyc && wb_stb && wb_ack) begin
                fetch_adr  = wb_adr;
                fetch_word = wb_dat_i;
            end
            if (stalled && !(inst_valid && inst_pc == stall_pc && inst_word == stall_word)) begin
                protocol_error("instruction dropped or changed while inst_ready was low");
            end
            if (inst_valid && !prev_valid) begin
                compare("inst_pc", exp_pc, inst_pc);
                compare("inst_pc vs wb_adr", fetch_adr, inst_pc);
                compare("inst_word", fetch_word, inst_word);
            end
            stalled    = inst_valid && !inst_ready;
            stall_pc   = inst_pc;
            stall_word = inst_word;
            if (inst_valid && inst_ready) begin
                transfers++;
                have_prev = 1'b1;
                prev_pc   = inst_pc;
                prev_word = inst_word;
                wait_redirect = (inst_word[6:0] == 7'b1100111) || (inst_word[6:0] == 7'b1100011);
                wait_md = (inst_word[6:0] == 7'b0110011) && (inst_word[31:25] == 7'b0000001);
            end
        end
        prev_cyc   = wb_cyc;
        prev_valid = inst_valid;
    end

endmodule

//--- sim/tb_fetch_top.sv
`timescale 1ns/100ps

module tb_fetch_top;

    localparam logic [31:0] RESET_VECTOR = 32'h8000_0000;
    localparam int N_TRANSFERS = 300;
    localparam int RUN_TIMEOUT = 20000;  // cycles

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_i;
    logic        wb_ack;
    logic        inst_valid;
    logic        inst_ready;
    logic [31:0] inst_pc;
    logic [31:0] inst_word;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        md_done;

    logic [31:0] lfsr;
    logic        cyc_s;      // bus state seen at the falling edge
    logic [31:0] adr_s;
    int          wait_cnt;
    int          cycles;
    logic        timed_out;

    fetch_top #(
        .RESET_VECTOR (RESET_VECTOR)
    ) DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_adr         (wb_adr),
        .wb_dat_i       (wb_dat_i),
        .wb_ack         (wb_ack),
        .inst_valid     (inst_valid),
        .inst_ready     (inst_ready),
        .inst_pc        (inst_pc),
        .inst_word      (inst_word),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .md_done        (md_done)
    );

    fetch_checker #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_adr         (wb_adr),
        .wb_dat_i       (wb_dat_i),
        .wb_ack         (wb_ack),
        .inst_valid     (inst_valid),
        .inst_ready     (inst_ready),
        .inst_pc        (inst_pc),
        .inst_word      (inst_word),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .md_done        (md_done)
    );

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // instruction mix hashed from the address
    function automatic logic [31:0] mem_word(input logic [31:0] adr);
        logic [31:0] h;
        logic [20:0] imm;
        h = adr ^ (adr >> 11) ^ (adr * 32'h9e37_79b9);
        h = h ^ (h >> 15);
        case (h[2:0])
            3'd4: begin
                imm = {12'd0, {1'b0, h[13:8]} + 7'd1, 2'b00};
                if (h[14]) begin
                    imm = -imm;
                end
                return {imm[20], imm[10:1], imm[11], imm[19:12], h[20:16], 7'b1101111};
            end
            3'd5: return {h[31:20], h[19:15], 3'b000, h[11:7], 7'b1100111};
            3'd6: return {h[31:25], h[24:20], h[19:15], h[14:12], h[11:7], 7'b1100011};
            3'd7: return {7'b0000001, h[24:20], h[19:15], h[3], 2'b00, h[11:7], 7'b0110011};
            default: return {h[31:20], h[19:15], 3'b000, h[11:7], 7'b0010011};
        endcase
    endfunction

    function automatic logic waits_redirect(input logic [31:0] w);
        return (w[6:0] == 7'b1100111) || (w[6:0] == 7'b1100011);
    endfunction

    function automatic logic waits_muldiv(input logic [31:0] w);
        return (w[6:0] == 7'b0110011) && (w[31:25] == 7'b0000001);
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin
        cyc_s = wb_cyc && wb_stb;
        adr_s = wb_adr;
    end

    // wishbone slave with 0..3 wait states and the consumer's ready
    always @(posedge clk) begin
        logic [31:0] r;
        logic [31:0] rdy;
        if (rst_n) begin
            if (cyc_s && !wb_ack) begin
                if (wait_cnt == 0) begin
                    wb_ack   <= 1'b1;
                    wb_dat_i <= mem_word(adr_s);
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end else begin
                wb_ack <= 1'b0;
                take_bits(2, r);
                wait_cnt <= int'(r[1:0]);
            end
            take_bits(1, rdy);
            inst_ready <= rdy[0];
        end
    end

    // execute stage model
    initial begin
        logic [31:0] w;
        logic [31:0] r;
        logic [31:0] target;
        forever begin
            @(negedge clk);
            if (rst_n && inst_valid && inst_ready) begin
                w = inst_word;
                if (waits_redirect(w) || waits_muldiv(w)) begin
                    take_bits(3, r);
                    if (waits_redirect(w)) begin
                        take_bits(22, target);
                    end
                    @(posedge clk);  // transfer edge
                    repeat (2 + int'(r[2:0])) @(posedge clk);
                    if (waits_redirect(w)) begin
                        redirect_valid <= 1'b1;
                        redirect_pc    <= {8'h80, target[21:0], 2'b00};
                    end else begin
                        md_done <= 1'b1;
                    end
                    @(posedge clk);
                    redirect_valid <= 1'b0;
                    md_done        <= 1'b0;
                end
            end
        end
    end

    initial begin
        lfsr           = 32'hf86e86e7;
        rst_n          = 1'b0;
        wb_dat_i       = '0;
        wb_ack         = 1'b0;
        inst_ready     = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        md_done        = 1'b0;
        wait_cnt       = 0;
        cyc_s          = 1'b0;
        adr_s          = '0;
        cycles         = 0;
        timed_out      = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        while (u_checker.transfers < N_TRANSFERS && !timed_out) begin
            @(posedge clk);
            cycles++;
            if (cycles > RUN_TIMEOUT) begin
                timed_out = 1'b1;
            end
        end
        if (timed_out) begin
            $display("timeout: only %0d of %0d instructions transferred",
                     u_checker.transfers, N_TRANSFERS);
        end
        $display("transfers %0d, errors %0d, protocol errors %0d",
                 u_checker.transfers, u_checker.value_errors, u_checker.protocol_errors);
        if (!timed_out && u_checker.value_errors == 0 && u_checker.protocol_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- sim.f
verilog/rv_isa_pkg.sv
verilog/fetch_pkg.sv
verilog/fetch_ifs.sv
verilog/wb_fetch_master.sv
verilog/pc_sequencer.sv
verilog/instr_issue.sv
verilog/fetch_top.sv
sim/fetch_checker.sv
sim/tb_fetch_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module tb_fetch_top -f sim.f -o tb_fetch_top
./obj_dir/tb_fetch_top | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
